// File: rtl/booth_mul_consts.svh
// widths fixed for the 24x24 unsigned core only, changing them alone does not rescale the tree
`ifndef BOOTH_MUL_CONSTS_SVH
`define BOOTH_MUL_CONSTS_SVH

// ================================================
// operand and partial product sizing
// ================================================

// unsigned operand width
`define MUL_SRC_WIDTH 24
// operand plus one zero msb so 2x still fits
`define MUL_PP_WIDTH 25
// radix-4 booth digits for a 25-bit multiplier
`define MUL_PP_ROWS 13

// ================================================
// carry-save result sizing
// ================================================
`define MUL_DST_WIDTH 50
// bits of out0 + out1 that hold the product
`define MUL_PROD_WIDTH 48

`endif

// File: rtl/booth_mul_pkg.sv
// vector types only, all widths come from the consts header
`default_nettype none

`include "booth_mul_consts.svh"

package booth_mul_pkg;

  // unsigned multiplier and multiplicand
  typedef logic [`MUL_SRC_WIDTH-1:0] mul_operand_t;

  // three overlapping multiplier bits per booth digit
  typedef logic [2:0] booth_window_t;

  // one selected and possibly inverted multiplicand
  typedef logic [`MUL_PP_WIDTH-1:0] booth_pp_t;

  // two's complement completion bits, land in the next row
  typedef logic [1:0] booth_hot_t;

  // aligned row, also one sum or carry word
  typedef logic [`MUL_DST_WIDTH-1:0] csa_word_t;

  // last compression level, one bit of sign extension
  typedef logic [`MUL_DST_WIDTH:0] csa_wide_t;

endpackage

`default_nettype wire

// File: rtl/booth_digit_sel.sv
// multiplicand msb must be zero, the -2x path drops it when shifting
`timescale 1ns/1ps
`default_nettype none

module booth_digit_sel
  import booth_mul_pkg::*;
(
  input  booth_pp_t     multiplicand,
  input  booth_window_t window,
  output booth_pp_t     product,
  output booth_hot_t    hot,
  output logic          sign_not
);

  // digit select lines
  logic sel_p1;
  logic sel_p2;
  logic sel_n1;
  logic sel_n2;

  // radix-4 recode, 000 and 111 both give a zero row
  always_comb begin
    sel_p1 = 1'b0;
    sel_p2 = 1'b0;
    sel_n1 = 1'b0;
    sel_n2 = 1'b0;
    case (window)
      3'b001, 3'b010: sel_p1 = 1'b1;
      3'b011:         sel_p2 = 1'b1;
      3'b100:         sel_n2 = 1'b1;
      3'b101, 3'b110: sel_n1 = 1'b1;
      default:        ;
    endcase
    assert ($onehot0({sel_p1, sel_p2, sel_n1, sel_n2}))
      else $error("booth_digit_sel: several selects active for window %b", window);
  end

  // and-or mux over the four magnitudes
  // -2x keeps lsb clear, hot[1] adds the 2 back
  assign product = ({`MUL_PP_WIDTH{sel_p1}} & multiplicand)
                 | ({`MUL_PP_WIDTH{sel_p2}} & {multiplicand[`MUL_PP_WIDTH-2:0], 1'b0})
                 | ({`MUL_PP_WIDTH{sel_n1}} & ~multiplicand)
                 | ({`MUL_PP_WIDTH{sel_n2}} & {~multiplicand[`MUL_PP_WIDTH-2:0], 1'b0});

  // +1 for -1x at bit 0, +2 for -2x at bit 1
  assign hot = {sel_n2, sel_n1};

  // row is negative only for the two minus digits
  assign sign_not = ~(sel_n1 | sel_n2);

endmodule

`default_nettype wire

// File: rtl/booth_pp_rows.sv
// unsigned only, both operands zero-extended so the top booth window never goes negative
`timescale 1ns/1ps
`default_nettype none

`include "booth_mul_consts.svh"

module booth_pp_rows
  import booth_mul_pkg::*;
(
  input  mul_operand_t                a,
  input  mul_operand_t                b,
  output csa_word_t [`MUL_PP_ROWS:0] rows
);

  booth_pp_t                 multiplicand;
  booth_pp_t                 mult_src;
  logic [`MUL_PP_WIDTH+1:0]  code;
  booth_pp_t                 pp [`MUL_PP_ROWS];
  booth_hot_t                hot [`MUL_PP_ROWS];
  logic [`MUL_PP_ROWS-1:0]   sign_not;

  // ================================================
  // operand extension and window string
  // ================================================

  // extra zero msb leaves room for 2x selection
  assign multiplicand = {1'b0, a};
  assign mult_src     = {1'b0, b};

  // implicit zero below lsb, msb repeated on top
  assign code = {mult_src[`MUL_PP_WIDTH-1], mult_src, 1'b0};

  // ================================================
  // digit selection and row placement
  // ================================================

  genvar i;
  for (i = 0; i < `MUL_PP_ROWS; i++) begin : g_digit
    // window i covers multiplier bits 2i+1 down to 2i-1
    booth_digit_sel u_digit (
      .multiplicand (multiplicand),
      .window       (code[2*i +: 3]),
      .product      (pp[i]),
      .hot          (hot[i]),
      .sign_not     (sign_not[i])
    );

    if (i == 0) begin : g_first
      // first row carries ~s s s above its product
      assign rows[i] = csa_word_t'({sign_not[i], ~sign_not[i], ~sign_not[i], pp[i]});
    end else begin : g_rest
      // 1 and ~s above, previous hot bits just below
      // last row loses its constant one past bit 49
      assign rows[i] = csa_word_t'({1'b1, sign_not[i], pp[i], hot[i-1]}) << (2*i - 2);
    end
  end

  // extra row for the final digit's hot bits
  assign rows[`MUL_PP_ROWS] =
    csa_word_t'(hot[`MUL_PP_ROWS-1]) << (2*`MUL_PP_ROWS - 2);

endmodule

`default_nettype wire

// File: rtl/csa_4to2.sv
// carry output is unshifted, the caller moves it up one bit before adding
`timescale 1ns/1ps
`default_nettype none

module csa_4to2 #(
  parameter int WIDTH = 50
) (
  input  logic [WIDTH-1:0] in0,
  input  logic [WIDTH-1:0] in1,
  input  logic [WIDTH-1:0] in2,
  input  logic [WIDTH-1:0] in3,
  output logic [WIDTH-1:0] sum,
  output logic [WIDTH-1:0] carry
);

  logic [WIDTH-1:0] maj;
  logic [WIDTH-1:0] par;
  logic [WIDTH-1:0] maj_up;

  // first full adder carry from in0..in2
  assign maj = (in0 & in1) | (in1 & in2) | (in0 & in2);

  // parity of all four inputs
  assign par = in0 ^ in1 ^ in2 ^ in3;

  // inner carry enters the next bit position
  assign maj_up = {maj[WIDTH-2:0], 1'b0};

  assign sum = par ^ maj_up;

  // odd parity passes the inner carry, even parity passes in3
  assign carry = (par & maj_up) | (~par & in3);

endmodule

`default_nettype wire

// File: rtl/booth_compress_tree.sv
// purely combinational, sum plus carry shifted by one equals the row total modulo 2^50
`timescale 1ns/1ps
`default_nettype none

`include "booth_mul_consts.svh"

module booth_compress_tree
  import booth_mul_pkg::*;
(
  input  csa_word_t [`MUL_PP_ROWS:0] rows,
  output csa_word_t                  sum,
  output csa_word_t                  carry
);

  csa_word_t l1_sum   [3];
  csa_word_t l1_carry [3];
  csa_word_t l2_sum   [2];
  csa_word_t l2_carry [2];
  csa_wide_t l3_sum;
  csa_wide_t l3_carry;

  // ================================================
  // level 1, twelve rows down to six words
  // ================================================
  genvar j;
  for (j = 0; j < 3; j++) begin : g_l1
    csa_4to2 #(.WIDTH(`MUL_DST_WIDTH)) u_csa (
      .in0   (rows[4*j]),
      .in1   (rows[4*j+1]),
      .in2   (rows[4*j+2]),
      .in3   (rows[4*j+3]),
      .sum   (l1_sum[j]),
      .carry (l1_carry[j])
    );
  end

  // ================================================
  // level 2, six words plus rows 12 and 13
  // ================================================
  csa_4to2 #(.WIDTH(`MUL_DST_WIDTH)) u_l2_0 (
    .in0   (l1_sum[0]),
    .in1   ({l1_carry[0][`MUL_DST_WIDTH-2:0], 1'b0}),
    .in2   (l1_sum[1]),
    .in3   ({l1_carry[1][`MUL_DST_WIDTH-2:0], 1'b0}),
    .sum   (l2_sum[0]),
    .carry (l2_carry[0])
  );

  // last partial product row and the trailing hot row join here
  csa_4to2 #(.WIDTH(`MUL_DST_WIDTH)) u_l2_1 (
    .in0   (l1_sum[2]),
    .in1   ({l1_carry[2][`MUL_DST_WIDTH-2:0], 1'b0}),
    .in2   (rows[`MUL_PP_ROWS-1]),
    .in3   (rows[`MUL_PP_ROWS]),
    .sum   (l2_sum[1]),
    .carry (l2_carry[1])
  );

  // ================================================
  // level 3, one bit wider
  // ================================================
  // sums sign-extended, carries keep their msb after the shift
  csa_4to2 #(.WIDTH(`MUL_DST_WIDTH+1)) u_l3 (
    .in0   ({l2_sum[0][`MUL_DST_WIDTH-1], l2_sum[0]}),
    .in1   ({l2_carry[0], 1'b0}),
    .in2   ({l2_sum[1][`MUL_DST_WIDTH-1], l2_sum[1]}),
    .in3   ({l2_carry[1], 1'b0}),
    .sum   (l3_sum),
    .carry (l3_carry)
  );

  // top bit of the wide level is dropped
  assign sum   = l3_sum[`MUL_DST_WIDTH-1:0];
  assign carry = l3_carry[`MUL_DST_WIDTH-1:0];

endmodule

`default_nettype wire

// File: rtl/booth_mul_24x24.sv
// unsigned only, no stall and no final adder, product is (out0 + out1) mod 2^48
`timescale 1ns/1ps
`default_nettype none

`include "booth_mul_consts.svh"

module booth_mul_24x24
  import booth_mul_pkg::*;
(
  input  logic         forever_cpuclk,
  input  logic         reset,
  input  logic         in_valid,
  input  mul_operand_t a,
  input  mul_operand_t b,
  output logic         out_valid,
  output csa_word_t    out0,
  output csa_word_t    out1
);

  mul_operand_t               ex1_a;
  mul_operand_t               ex1_b;
  logic                       ex1_valid;
  csa_word_t [`MUL_PP_ROWS:0] ex1_rows;
  csa_word_t                  ex1_sum;
  csa_word_t                  ex1_carry;

  // ================================================
  // valid pipeline
  // ================================================
  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      ex1_valid <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      ex1_valid <= in_valid;
      out_valid <= ex1_valid;
    end
  end

  // operands only load on a strobe
  always_ff @(posedge forever_cpuclk) begin
    if (in_valid) begin
      ex1_a <= a;
      ex1_b <= b;
    end
  end

  // ================================================
  // booth rows and compression, one cycle of logic
  // ================================================
  booth_pp_rows u_rows (
    .a    (ex1_a),
    .b    (ex1_b),
    .rows (ex1_rows)
  );

  booth_compress_tree u_tree (
    .rows  (ex1_rows),
    .sum   (ex1_sum),
    .carry (ex1_carry)
  );

  // result pair holds between valid pulses
  // carry word moves up one bit here
  always_ff @(posedge forever_cpuclk) begin
    if (ex1_valid) begin
      out0 <= ex1_sum;
      out1 <= {ex1_carry[`MUL_DST_WIDTH-2:0], 1'b0};
    end
  end

  // valid must clear one cycle after any reset edge
  assert property (@(posedge forever_cpuclk) reset |=> !out_valid)
    else $error("booth_mul_24x24: out_valid high after reset");

  // two stages of latency once reset has been low for two edges
  assert property (@(posedge forever_cpuclk)
    ($past(!reset, 1) && $past(!reset, 2)) |-> (out_valid == $past(in_valid, 2)))
    else $error("booth_mul_24x24: out_valid does not follow in_valid by two cycles");

endmodule

`default_nettype wire

// File: verif/tb_booth_mul.sv
// checks only (out0 + out1) mod 2^48 against a*b and changes inputs on the falling edge only
`timescale 1ns/1ps
`default_nettype none

`include "booth_mul_consts.svh"

module tb_booth_mul
  import booth_mul_pkg::*;
();

  logic         clk;
  logic         reset;
  logic         in_valid;
  mul_operand_t a;
  mul_operand_t b;
  logic         out_valid;
  csa_word_t    out0;
  csa_word_t    out1;

  // expected products oldest first
  logic [`MUL_PROD_WIDTH-1:0] expect_q [$];
  logic [`MUL_PROD_WIDTH-1:0] exp_prod;
  logic [`MUL_PROD_WIDTH-1:0] got_prod;
  int                         errors;
  int                         checks;
  int                         accepted;
  int                         pulses;
  integer                     seed;

  booth_mul_24x24 UUT (
    .forever_cpuclk (clk),
    .reset          (reset),
    .in_valid       (in_valid),
    .a              (a),
    .b              (b),
    .out_valid      (out_valid),
    .out0           (out0),
    .out1           (out1)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ================================================
  // scoreboard
  // ================================================

  // pair enters the queue on the edge that samples it
  always @(posedge clk) begin
    if (!reset && in_valid) begin
      expect_q.push_back({{(`MUL_PROD_WIDTH-`MUL_SRC_WIDTH){1'b0}}, a} *
                         {{(`MUL_PROD_WIDTH-`MUL_SRC_WIDTH){1'b0}}, b});
      accepted++;
    end
  end

  // outputs read half a cycle after they settle
  always @(negedge clk) begin
    if (!reset && out_valid) begin
      pulses++;
      assert (expect_q.size() != 0)
        else begin
          $display("out_valid pulse with no pair in flight");
          errors++;
        end
      if (expect_q.size() != 0) begin
        exp_prod = expect_q.pop_front();
        got_prod = out0[`MUL_PROD_WIDTH-1:0] + out1[`MUL_PROD_WIDTH-1:0];
        checks++;
        assert (got_prod == exp_prod)
          else begin
            $display("CHECK FAILED out0+out1 got %h expected %h", got_prod, exp_prod);
            errors++;
          end
      end
    end
  end

  // ================================================
  // helpers
  // ================================================
  task automatic check_valid(input logic expected);
    checks++;
    assert (out_valid == expected)
      else begin
        $display("CHECK FAILED out_valid got %h expected %h", out_valid, expected);
        errors++;
      end
  endtask

  // one pair with the strobe dropped on the next falling edge
  task automatic drive_pair(input mul_operand_t x, input mul_operand_t y);
    @(negedge clk);
    a        = x;
    b        = y;
    in_valid = 1'b1;
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  // bounded wait for every queued result
  task automatic wait_drain();
    int n;
    n = 0;
    while (expect_q.size() != 0 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (expect_q.size() != 0) begin
      $display("timeout waiting for out_valid, %0d results missing", expect_q.size());
      errors++;
    end
  endtask

  // ================================================
  // directed tests
  // ================================================
  task automatic idle_after_reset();
    repeat (10) begin
      @(negedge clk);
      check_valid(1'b0);
    end
  endtask

  // every digit value including -2x from 0xaaaaaa and +2x from 0x666666
  task automatic corner_operands();
    mul_operand_t vals [7];
    vals = '{24'h000000, 24'h000001, 24'hffffff, 24'h800000,
             24'h555555, 24'haaaaaa, 24'h666666};
    foreach (vals[i]) begin
      foreach (vals[j]) begin
        drive_pair(vals[i], vals[j]);
      end
    end
    wait_drain();
  endtask

  // fixed two-edge latency and a one cycle wide pulse
  task automatic single_pair_timing();
    drive_pair(24'h123456, 24'h654321);
    check_valid(1'b0);
    @(negedge clk);
    check_valid(1'b1);
    @(negedge clk);
    check_valid(1'b0);
    wait_drain();
  endtask

  // four pairs on four edges with pulses at falling edges 2..5
  task automatic back_to_back();
    for (int i = 0; i < 7; i++) begin
      @(negedge clk);
      check_valid(i >= 2 && i <= 5);
      if (i < 4) begin
        a        = mul_operand_t'(24'h00f00f * (i + 1));
        b        = mul_operand_t'(24'hfedcba - i);
        in_valid = 1'b1;
      end else begin
        in_valid = 1'b0;
      end
    end
    wait_drain();
  endtask

  task automatic random_pairs();
    int gap;
    for (int k = 0; k < 200; k++) begin
      gap = $random(seed) & 3;
      repeat (gap) @(negedge clk);
      drive_pair(mul_operand_t'($random(seed)), mul_operand_t'($random(seed)));
    end
    wait_drain();
    checks++;
    assert (pulses == accepted)
      else begin
        $display("CHECK FAILED pulses got %h expected %h", pulses, accepted);
        errors++;
      end
  endtask

  // ================================================
  // main sequence
  // ================================================
  initial begin
    reset    = 1'b1;
    in_valid = 1'b0;
    a        = '0;
    b        = '0;
    errors   = 0;
    checks   = 0;
    accepted = 0;
    pulses   = 0;
    seed     = 32'hb89d3f8a;
    repeat (8) @(negedge clk);
    reset = 1'b0;

    idle_after_reset();
    corner_operands();
    single_pair_timing();
    back_to_back();
    random_pairs();

    $display("checks %0d, errors %0d, pairs %0d", checks, errors, accepted);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+rtl
rtl/booth_mul_pkg.sv
rtl/booth_digit_sel.sv
rtl/booth_pp_rows.sv
rtl/csa_4to2.sv
rtl/booth_compress_tree.sv
rtl/booth_mul_24x24.sv
verif/tb_booth_mul.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module tb_booth_mul -Mdir obj_dir
	./obj_dir/Vtb_booth_mul | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
